//--- rtl/framerPkg.sv
// Shared types and constants of the stream framer
// Sample width, lane and output beat structs, AXI response code

package framerPkg;

  // Width of one sample on every input stream
  localparam int unsigned DataBits = 16;

  // Width of the lane tag on the merged output
  // Fixed, so up to 16 lanes fit
  localparam int unsigned LaneTagBits = 4;

  // AXI response codes
  // Only OKAY is ever returned
  localparam logic [1:0] respOkay = 2'b00;

  // One beat leaving a marker lane
  typedef struct packed {
    logic [DataBits-1:0] data;
    // High on the period-th beat
    logic                last;
  } laneBeatT;

  // One beat on the merged output link
  typedef struct packed {
    // Source lane of this beat
    logic [LaneTagBits-1:0] lane;
    logic [DataBits-1:0]    data;
    // Closes the packet of that lane
    logic                   last;
  } outBeatT;

  // Lane tag plus lane beat
  // 4 + 16 + 1 = 21 bits

endpackage : framerPkg

//--- rtl/cfgSlave.sv
// AXI-lite configuration slave
// Per-lane period registers, update pulses and read-back
`timescale 1ns/1ps

module cfgSlave #(
  parameter int unsigned           NumLanes   = 4,
  parameter int unsigned           AddrBits   = 2,
  parameter int unsigned           PeriodBits = 8,
  parameter logic [PeriodBits-1:0] PeriodInit = 4
) (
  input  logic ap_clk,
  input  logic ap_rst_n,

  // Write address channel
  input  logic                  cfgAwValid,
  output logic                  cfgAwReady,
  input  logic [AddrBits-1:0]   cfgAwAddr,
  // Write data channel
  input  logic                  cfgWValid,
  output logic                  cfgWReady,
  input  logic [PeriodBits-1:0] cfgWData,
  // Write response channel
  output logic                  cfgBValid,
  input  logic                  cfgBReady,
  output logic [1:0]            cfgBResp,

  // Read address channel
  input  logic                  cfgArValid,
  output logic                  cfgArReady,
  input  logic [AddrBits-1:0]   cfgArAddr,
  // Read data channel
  output logic                  cfgRValid,
  input  logic                  cfgRReady,
  output logic [PeriodBits-1:0] cfgRData,
  output logic [1:0]            cfgRResp,

  // Lane side
  output logic [NumLanes-1:0][PeriodBits-1:0] period,
  output logic [NumLanes-1:0]                 periodUpdate
);

  // Write side state
  logic                  wAddrRdy;
  logic                  wDataRdy;
  logic [AddrBits-1:0]   wAddr;
  logic [PeriodBits-1:0] wData;
  logic                  bVld;
  logic                  wr;

  // Read side state
  logic                  rVld;
  logic [PeriodBits-1:0] rData;

  // Both halves held and no response pending
  assign wr = !wAddrRdy && !wDataRdy && !bVld;

  // Address and data accepted independently
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || wr) begin
      wAddrRdy <= 1'b1;
      wDataRdy <= 1'b1;
    end else begin
      if (wAddrRdy && cfgAwValid) begin
        wAddrRdy <= 1'b0;
      end
      if (wDataRdy && cfgWValid) begin
        wDataRdy <= 1'b0;
      end
    end
  end

  // Captured write payload
  always_ff @(posedge ap_clk) begin
    if (wAddrRdy && cfgAwValid) begin
      wAddr <= cfgAwAddr;
    end
    if (wDataRdy && cfgWValid) begin
      wData <= cfgWData;
    end
  end

  // Response raised by the write, held until taken
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      bVld <= 1'b0;
    end else if (wr) begin
      bVld <= 1'b1;
    end else if (cfgBReady) begin
      bVld <= 1'b0;
    end
  end

  // Period registers
  // Update pulse in the same cycle the new value shows up
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      period       <= {NumLanes{PeriodInit}};
      periodUpdate <= '0;
    end else begin
      periodUpdate <= '0;
      for (int i = 0; i < NumLanes; i++) begin
        if (wr && wAddr == AddrBits'(i)) begin
          period[i]       <= wData;
          periodUpdate[i] <= 1'b1;
        end
      end
    end
  end

  // Read valid, cleared once the master takes it
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rVld <= 1'b0;
    end else begin
      rVld <= rVld ? !cfgRReady : cfgArValid;
    end
  end

  // Read data sampled with the address
  // Unmapped lanes read as zero
  always_ff @(posedge ap_clk) begin
    if (!rVld && cfgArValid) begin
      rData <= (int'(cfgArAddr) < NumLanes) ? period[cfgArAddr] : '0;
    end
  end

  assign cfgAwReady = wAddrRdy;
  assign cfgWReady  = wDataRdy;
  assign cfgBValid  = bVld;
  assign cfgBResp   = framerPkg::respOkay;

  assign cfgArReady = !rVld;
  assign cfgRValid  = rVld;
  assign cfgRData   = rData;
  assign cfgRResp   = framerPkg::respOkay;

endmodule : cfgSlave

//--- rtl/markerLane.sv
// Last-beat marker for one sample stream
// Signed down-counter with clean flag
`timescale 1ns/1ps

module markerLane #(
  parameter int unsigned           PeriodBits = 8,
  parameter logic [PeriodBits-1:0] PeriodInit = 4
) (
  input  logic ap_clk,
  input  logic ap_rst_n,

  // Source stream
  input  logic [framerPkg::DataBits-1:0] srcData,
  input  logic                           srcValid,
  output logic                           srcReady,

  // Configuration
  input  logic [PeriodBits-1:0] period,
  input  logic                  periodUpdate,

  // Marked stream towards the merger
  output framerPkg::laneBeatT laneBeat,
  output logic                laneValid,
  input  logic                laneReady
);

  // Counts P-2 down to -1, sign bit marks the last beat
  logic signed [PeriodBits:0] cnt;
  logic [PeriodBits:0]        reloadVal;
  logic                       clean;
  logic                       last;
  logic                       beatTaken;

  localparam logic [PeriodBits:0] CntInit = {1'b0, PeriodInit} - (PeriodBits + 1)'(2);

  assign last      = cnt[PeriodBits];
  assign beatTaken = srcValid && laneReady;
  // Start value for the current period
  assign reloadVal = {1'b0, period} - (PeriodBits + 1)'(2);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cnt   <= CntInit;
      clean <= 1'b1;
    end else if (beatTaken) begin
      if (last) begin
        // Packet closed, pick up current period
        cnt   <= reloadVal;
        clean <= 1'b1;
      end else begin
        cnt   <= cnt - (PeriodBits + 1)'(1);
        clean <= 1'b0;
      end
    end else if (periodUpdate && clean) begin
      // Nothing sent yet, new period at once
      cnt <= reloadVal;
    end
  end

  // Data and flow control untouched
  assign laneBeat.data = srcData;
  assign laneBeat.last = last;
  assign laneValid     = srcValid;
  assign srcReady      = laneReady;

endmodule : markerLane

//--- rtl/packetMerger.sv
// Packet-atomic round-robin merger
// Grant locked between packet boundaries, one registered output beat
`timescale 1ns/1ps

module packetMerger #(
  parameter int unsigned NumLanes = 4
) (
  input  logic ap_clk,
  input  logic ap_rst_n,

  // Lanes from the markers
  input  framerPkg::laneBeatT [NumLanes-1:0] laneBeat,
  input  logic [NumLanes-1:0]                laneValid,
  output logic [NumLanes-1:0]                laneReady,

  // Merged output
  output framerPkg::outBeatT dstBeat,
  output logic               dstValid,
  input  logic               dstReady
);

  localparam int unsigned LaneBits = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  // Lane of the current or most recent packet
  logic [LaneBits-1:0] curLane;
  // Mid-packet, grant may not move
  logic                locked;
  // Next valid lane after curLane
  logic [LaneBits-1:0] nextLane;
  logic [LaneBits-1:0] selLane;
  logic                loadOut;
  logic                take;
  framerPkg::laneBeatT selBeat;

  // Round-robin search
  // Lowest offset after curLane wins, curLane itself is last in line
  always_comb begin
    int idx;
    nextLane = curLane;
    for (int k = NumLanes; k >= 1; k--) begin
      idx = (int'(curLane) + k) % NumLanes;
      if (laneValid[idx]) begin
        nextLane = LaneBits'(idx);
      end
    end
  end

  assign selLane = locked ? curLane : nextLane;
  assign selBeat = laneBeat[selLane];

  // Output register empty or draining this cycle
  assign loadOut = !dstValid || dstReady;
  assign take    = loadOut && laneValid[selLane];

  // Ready only to the granted lane
  always_comb begin
    laneReady = '0;
    laneReady[selLane] = loadOut;
  end

  // Grant pointer and lock
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      // Lane 0 first after reset
      curLane <= LaneBits'(NumLanes - 1);
      locked  <= 1'b0;
    end else if (take) begin
      curLane <= selLane;
      locked  <= !selBeat.last;
    end
  end

  // Output valid
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      dstValid <= 1'b0;
    end else if (take) begin
      dstValid <= 1'b1;
    end else if (dstReady) begin
      dstValid <= 1'b0;
    end
  end

  // Output payload, tagged with its lane
  always_ff @(posedge ap_clk) begin
    if (take) begin
      dstBeat.lane <= framerPkg::LaneTagBits'(selLane);
      dstBeat.data <= selBeat.data;
      dstBeat.last <= selBeat.last;
    end
  end

endmodule : packetMerger

//--- rtl/streamFramer.sv
// Stream framer top level
// Config slave, one marker per lane, packet merger
`timescale 1ns/1ps

module streamFramer #(
  // At most 16 lanes, bounded by the output lane tag
  parameter int unsigned           NumLanes   = 4,
  parameter int unsigned           PeriodBits = 8,
  parameter logic [PeriodBits-1:0] PeriodInit = 4
) (
  input  logic ap_clk,
  input  logic ap_rst_n,

  // AXI-lite configuration, address is the lane index
  input  logic                                   cfgAwValid,
  output logic                                   cfgAwReady,
  input  logic [((NumLanes > 1) ? $clog2(NumLanes) : 1)-1:0] cfgAwAddr,
  input  logic                                   cfgWValid,
  output logic                                   cfgWReady,
  input  logic [PeriodBits-1:0]                  cfgWData,
  output logic                                   cfgBValid,
  input  logic                                   cfgBReady,
  output logic [1:0]                             cfgBResp,
  input  logic                                   cfgArValid,
  output logic                                   cfgArReady,
  input  logic [((NumLanes > 1) ? $clog2(NumLanes) : 1)-1:0] cfgArAddr,
  output logic                                   cfgRValid,
  input  logic                                   cfgRReady,
  output logic [PeriodBits-1:0]                  cfgRData,
  output logic [1:0]                             cfgRResp,

  // Sample streams
  input  logic [NumLanes-1:0][framerPkg::DataBits-1:0] srcData,
  input  logic [NumLanes-1:0]                          srcValid,
  output logic [NumLanes-1:0]                          srcReady,

  // Merged packet stream
  output framerPkg::outBeatT dstBeat,
  output logic               dstValid,
  input  logic               dstReady
);

  localparam int unsigned AddrBits = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic [NumLanes-1:0][PeriodBits-1:0] period;
  logic [NumLanes-1:0]                 periodUpdate;
  framerPkg::laneBeatT [NumLanes-1:0]  laneBeat;
  logic [NumLanes-1:0]                 laneValid;
  logic [NumLanes-1:0]                 laneReady;

  cfgSlave #(
    .NumLanes  (NumLanes),
    .AddrBits  (AddrBits),
    .PeriodBits(PeriodBits),
    .PeriodInit(PeriodInit)
  ) uCfg (
    .ap_clk, .ap_rst_n,
    .cfgAwValid, .cfgAwReady, .cfgAwAddr, .cfgWValid, .cfgWReady, .cfgWData,
    .cfgBValid, .cfgBReady, .cfgBResp,
    .cfgArValid, .cfgArReady, .cfgArAddr, .cfgRValid, .cfgRReady, .cfgRData, .cfgRResp,
    .period, .periodUpdate
  );

  // One marker per input stream
  for (genvar i = 0; i < NumLanes; i++) begin : genLane
    markerLane #(
      .PeriodBits(PeriodBits),
      .PeriodInit(PeriodInit)
    ) uMarker (
      .ap_clk, .ap_rst_n,
      .srcData     (srcData[i]),
      .srcValid    (srcValid[i]),
      .srcReady    (srcReady[i]),
      .period      (period[i]),
      .periodUpdate(periodUpdate[i]),
      .laneBeat    (laneBeat[i]),
      .laneValid   (laneValid[i]),
      .laneReady   (laneReady[i])
    );
  end : genLane

  packetMerger #(
    .NumLanes(NumLanes)
  ) uMerger (
    .ap_clk, .ap_rst_n,
    .laneBeat, .laneValid, .laneReady,
    .dstBeat, .dstValid, .dstReady
  );

endmodule : streamFramer

//--- test/framerChecker_checker.sv
// Protocol assertions on the merged output and the config response
// Bound into the framer top, next to the merger outputs
`timescale 1ns/1ps

module framerChecker (
  input logic               ap_clk,
  input logic               ap_rst_n,
  input framerPkg::outBeatT dstBeat,
  input logic               dstValid,
  input logic               dstReady,
  input logic               cfgBValid
);

  // Packet in flight and its lane
  logic                              inPacket;
  logic [framerPkg::LaneTagBits-1:0] pktLane;
  // Failed assertions so far
  int unsigned                       assertFails = 0;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      inPacket <= 1'b0;
    end else if (dstValid && dstReady) begin
      inPacket <= !dstBeat.last;
      pktLane  <= dstBeat.lane;
    end
  end

  // Stalled beat held as is
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    dstValid && !dstReady |=> dstValid && $stable(dstBeat))
    else begin
      $error("Output beat dropped or changed while stalled");
      assertFails++;
    end

  // Same lane from first to last beat
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    dstValid && inPacket |-> dstBeat.lane == pktLane)
    else begin
      $error("Packet interleaved with another lane");
      assertFails++;
    end

  // Responses quiet once reset is seen
  assert property (@(posedge ap_clk) !ap_rst_n |=> !cfgBValid && !dstValid)
    else begin
      $error("Valid high in the cycle after reset");
      assertFails++;
    end

endmodule : framerChecker

bind streamFramer framerChecker uChecker (
  .ap_clk, .ap_rst_n, .dstBeat, .dstValid, .dstReady, .cfgBValid
);

//--- test/framerTb.sv
// Directed testbench for the stream framer
// Clock, reset, lane drivers, scoreboard, tests and timeout
`timescale 1ns/1ps

module framerTb;

  localparam int unsigned           NumLanes   = 4;
  localparam int unsigned           PeriodBits = 8;
  localparam logic [PeriodBits-1:0] PeriodInit = 4;
  // Tests need well under 1000 cycles, even with output stalls
  localparam int unsigned           MaxCycles  = 4000;

  logic ap_clk;
  logic ap_rst_n;
  logic cfgAwValid, cfgAwReady, cfgWValid, cfgWReady, cfgBValid, cfgBReady;
  logic cfgArValid, cfgArReady, cfgRValid, cfgRReady;
  logic [1:0] cfgAwAddr, cfgArAddr, cfgBResp, cfgRResp;
  logic [PeriodBits-1:0] cfgWData, cfgRData;
  logic [NumLanes-1:0][framerPkg::DataBits-1:0] srcData;
  logic [NumLanes-1:0] srcValid, srcReady;
  framerPkg::outBeatT dstBeat;
  logic dstValid, dstReady;

  // Samples waiting at each source, beats expected at the output
  logic [framerPkg::DataBits-1:0] srcQ[NumLanes][$];
  framerPkg::outBeatT expQ[NumLanes][$];
  // Register value, length of packet in progress, beats sent in it
  int unsigned modelPer[NumLanes];
  int unsigned pktPer[NumLanes];
  int unsigned beatCnt[NumLanes];
  // Lanes of packets in output order
  int unsigned pktOrder[$];
  int unsigned lastPktLane = NumLanes - 1;
  bit inPacket = 1'b0;
  bit randReady = 1'b0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cycles = 0;

  streamFramer #(
    .NumLanes  (NumLanes),
    .PeriodBits(PeriodBits),
    .PeriodInit(PeriodInit)
  ) uut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  task automatic checkBeat(input framerPkg::outBeatT got, input framerPkg::outBeatT want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH %0t dstBeat got lane=%0d data=%h last=%b, expected lane=%0d data=%h last=%b",
        $time, got.lane, got.data, got.last, want.lane, want.data, want.last);
    end
  endtask

  task automatic checkPeriod(input logic [PeriodBits-1:0] got, input logic [PeriodBits-1:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH %0t cfgRData got %0d, expected %0d", $time, got, want);
    end
  endtask

  task automatic checkResp(input string name, input logic [1:0] got);
    checks++;
    if (got !== framerPkg::respOkay) begin
      errors++;
      $display("MISMATCH %0t %s got %b, expected %b", $time, name, got, framerPkg::respOkay);
    end
  endtask

  // Sources and output ready, 1 ns after the edge
  always @(posedge ap_clk) begin
    #1;
    for (int l = 0; l < NumLanes; l++) begin
      srcValid[l] = srcQ[l].size() != 0;
      if (srcValid[l]) begin
        srcData[l] = srcQ[l][0];
      end else begin
        srcData[l] = '0;
      end
    end
    dstReady = randReady ? ($urandom_range(3) != 0) : 1'b1;
  end

  // Scoreboard, sampled mid-cycle while everything is stable
  always @(negedge ap_clk) begin
    framerPkg::outBeatT want;
    if (ap_rst_n) begin
      for (int l = 0; l < NumLanes; l++) begin
        if (srcValid[l] && srcReady[l]) begin
          // Lane model predicts the last flag
          beatCnt[l]++;
          want.lane = framerPkg::LaneTagBits'(l);
          want.data = srcData[l];
          want.last = beatCnt[l] == pktPer[l];
          if (want.last) begin
            beatCnt[l] = 0;
            pktPer[l]  = modelPer[l];
          end
          expQ[l].push_back(want);
          void'(srcQ[l].pop_front());
        end
      end
      if (dstValid && dstReady) begin
        if (int'(dstBeat.lane) >= NumLanes || expQ[dstBeat.lane].size() == 0) begin
          errors++;
          $display("Output beat of lane %0d at %0t has no sample waiting", dstBeat.lane, $time);
        end else begin
          if (!inPacket) begin
            lastPktLane = dstBeat.lane;
            pktOrder.push_back(dstBeat.lane);
          end else if (dstBeat.lane != lastPktLane) begin
            errors++;
            $display("Lane %0d beat inside a lane %0d packet at %0t",
              dstBeat.lane, lastPktLane, $time);
          end
          checkBeat(dstBeat, expQ[dstBeat.lane].pop_front());
        end
        inPacket = !dstBeat.last;
      end
    end
  end

  task automatic writePeriod(input int unsigned lane, input int unsigned value);
    bit awDone;
    bit wDone;
    @(posedge ap_clk);
    #1;
    cfgAwValid = 1'b1;
    cfgAwAddr  = 2'(lane);
    cfgWValid  = 1'b1;
    cfgWData   = PeriodBits'(value);
    while (cfgAwValid || cfgWValid) begin
      @(negedge ap_clk);
      awDone = cfgAwValid && cfgAwReady;
      wDone  = cfgWValid && cfgWReady;
      @(posedge ap_clk);
      #1;
      if (awDone) cfgAwValid = 1'b0;
      if (wDone) cfgWValid = 1'b0;
    end
    cfgBReady = 1'b1;
    @(negedge ap_clk);
    while (!cfgBValid) @(negedge ap_clk);
    checkResp("cfgBResp", cfgBResp);
    // Clean lane picks up the new period at once
    modelPer[lane] = value;
    if (beatCnt[lane] == 0) pktPer[lane] = value;
    @(posedge ap_clk);
    #1;
    cfgBReady = 1'b0;
  endtask

  task automatic readPeriod(input int unsigned lane);
    @(posedge ap_clk);
    #1;
    cfgArValid = 1'b1;
    cfgArAddr  = 2'(lane);
    cfgRReady  = 1'b1;
    @(negedge ap_clk);
    while (!cfgArReady) @(negedge ap_clk);
    @(posedge ap_clk);
    #1;
    cfgArValid = 1'b0;
    @(negedge ap_clk);
    while (!cfgRValid) @(negedge ap_clk);
    checkPeriod(cfgRData, PeriodBits'(modelPer[lane]));
    checkResp("cfgRResp", cfgRResp);
    @(posedge ap_clk);
    #1;
    cfgRReady = 1'b0;
  endtask

  // Random samples into one source queue
  task automatic loadBeats(input int unsigned lane, input int unsigned count);
    @(negedge ap_clk);
    #1;
    repeat (count) srcQ[lane].push_back(framerPkg::DataBits'($urandom));
  endtask

  // Whole packets on every lane, all queued in the same cycle
  task automatic loadPackets(input int unsigned minPkts, input int unsigned maxPkts);
    @(negedge ap_clk);
    #1;
    for (int l = 0; l < NumLanes; l++) begin
      repeat ($urandom_range(maxPkts, minPkts) * modelPer[l]) begin
        srcQ[l].push_back(framerPkg::DataBits'($urandom));
      end
    end
  endtask

  // Until every queued sample has left the output
  task automatic waitDrain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge ap_clk);
      #1;
      busy = 1'b0;
      for (int l = 0; l < NumLanes; l++) begin
        if (srcQ[l].size() != 0 || expQ[l].size() != 0) busy = 1'b1;
      end
    end
  endtask

  task automatic resetDefaults();
    for (int l = 0; l < NumLanes; l++) readPeriod(l);
    loadPackets(2, 2);
    waitDrain();
  endtask

  task automatic periodWrites();
    writePeriod(0, 3);
    writePeriod(1, 5);
    writePeriod(2, 1);
    writePeriod(3, 6);
    for (int l = 0; l < NumLanes; l++) readPeriod(l);
    loadPackets(2, 2);
    waitDrain();
  endtask

  // Period change while lane 1 sits in the middle of a packet
  task automatic midPacketWrite();
    loadBeats(1, 1);
    waitDrain();
    writePeriod(1, 3);
    readPeriod(1);
    loadBeats(1, pktPer[1] - beatCnt[1] + 2 * 3);
    waitDrain();
  endtask

  task automatic roundRobinOrder();
    int unsigned prev;
    prev = lastPktLane;
    pktOrder.delete();
    loadPackets(2, 2);
    waitDrain();
    if (pktOrder.size() != 2 * NumLanes) begin
      errors++;
      $display("Saw %0d packets with all lanes busy, expected %0d", pktOrder.size(), 2 * NumLanes);
    end
    foreach (pktOrder[i]) begin
      prev = (prev + 1) % NumLanes;
      if (pktOrder[i] != prev) begin
        errors++;
        $display("Packet %0d granted to lane %0d, round robin expects lane %0d",
          i, pktOrder[i], prev);
      end
    end
  endtask

  task automatic stalledOutput();
    randReady = 1'b1;
    repeat (3) begin
      loadPackets(1, 3);
      waitDrain();
    end
    randReady = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h8b7021bc));
    ap_rst_n   = 1'b0;
    cfgAwValid = 1'b0;
    cfgAwAddr  = '0;
    cfgWValid  = 1'b0;
    cfgWData   = '0;
    cfgBReady  = 1'b0;
    cfgArValid = 1'b0;
    cfgArAddr  = '0;
    cfgRReady  = 1'b0;
    srcData    = '0;
    srcValid   = '0;
    dstReady   = 1'b1;
    for (int l = 0; l < NumLanes; l++) begin
      modelPer[l] = PeriodInit;
      pktPer[l]   = PeriodInit;
      beatCnt[l]  = 0;
    end
    repeat (3) @(posedge ap_clk);
    #1;
    ap_rst_n = 1'b1;
    resetDefaults();
    periodWrites();
    midPacketWrite();
    roundRobinOrder();
    stalledOutput();
    // Assertion failures of the bound checker
    errors += uut.uChecker.assertFails;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Stuck handshake guard
  initial begin
    while (cycles < MaxCycles) begin
      @(posedge ap_clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, a handshake never completed", cycles);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule : framerTb

//--- files.f
rtl/framerPkg.sv
rtl/cfgSlave.sv
rtl/markerLane.sv
rtl/packetMerger.sv
rtl/streamFramer.sv
test/framerChecker_checker.sv
test/framerTb.sv

//--- Makefile
# Verilator build and run for the stream framer testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = framerTb
FILELIST  = files.f
OBJDIR    = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Output goes to the console, the pass line decides the exit status
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
